// File: src/ialu_pkg.sv
//----------------------------------------------------------
// IALU shared definitions
// Operand width, command encoding, adder flags and the
// radix-2 multiplier FSM and counter constants
//----------------------------------------------------------

package ialu_pkg;

    //----------------------------------------------------------
    // Widths
    //----------------------------------------------------------

    localparam int XLEN    = 32;                // Operand width
    localparam int SHAMT_W = 5;                 // Shift amount width, low bits of op2

    //----------------------------------------------------------
    // IALU command encoding
    //----------------------------------------------------------

    typedef enum logic [4:0] {
        ADD,                                    // op1 + op2
        SUB,                                    // op1 - op2
        SUB_LT,                                 // Signed less than
        SUB_LTU,                                // Unsigned less than
        SUB_EQ,                                 // Equal
        SUB_NE,                                 // Not equal
        SUB_GE,                                 // Signed greater or equal
        SUB_GEU,                                // Unsigned greater or equal
        AND,
        OR,
        XOR,
        SLL,                                    // Logical left
        SRL,                                    // Logical right
        SRA,                                    // Arithmetic right
        MUL,                                    // Low word, signed x signed
        MULH,                                   // High word, signed x signed
        MULHSU,                                 // High word, signed x unsigned
        MULHU,                                  // High word, unsigned x unsigned
        NONE
    } ialu_cmd_e;

    // Main adder flags, valid for subtraction
    typedef struct packed {
        logic z;                                // Zero
        logic s;                                // Sign
        logic o;                                // Signed overflow
        logic c;                                // Carry, i.e. unsigned borrow
    } ialu_flags_s;

    //----------------------------------------------------------
    // Multiplier
    //----------------------------------------------------------

    // One-hot counter preload, reaches bit 0 after 30 shifts
    localparam logic [XLEN-1:0] MUL_CNT_INIT = XLEN'(1) << (XLEN - 2);

    typedef enum logic {
        IDLE,                                   // First step, ready for zero operands
        ITER                                    // Remaining 31 steps
    } mdu_state_e;

endpackage : ialu_pkg

// File: src/ialu_main_adder.sv
//----------------------------------------------------------
// IALU main adder
// ADD, SUB and the subtract-based comparisons, with flags
//----------------------------------------------------------

`timescale 1ns/1ns

module ialu_main_adder (
    input  ialu_pkg::ialu_cmd_e          cmd_i,     // IALU command
    input  logic [ialu_pkg::XLEN-1:0]    op1_i,     // 1st operand
    input  logic [ialu_pkg::XLEN-1:0]    op2_i,     // 2nd operand
    output logic [ialu_pkg::XLEN-1:0]    sum_o,     // Sum or difference
    output ialu_pkg::ialu_flags_s        flags_o    // Flags for comparisons
);

    logic                       is_sub;             // Anything but ADD subtracts
    logic [ialu_pkg::XLEN:0]    sum_full;           // Extra top bit is the carry
    logic                       op1_sgn;
    logic                       op2_eff_sgn;        // op2 sign as seen by the adder
    logic                       res_sgn;

    //----------------------------------------------------------
    // Add / subtract
    //----------------------------------------------------------

    assign is_sub = (cmd_i != ialu_pkg::ADD);

    always_comb begin
        if (is_sub) begin
            sum_full = {1'b0, op1_i} - {1'b0, op2_i};   // Comparisons land here too
        end else begin
            sum_full = {1'b0, op1_i} + {1'b0, op2_i};
        end
    end

    assign sum_o = sum_full[ialu_pkg::XLEN-1:0];

    //----------------------------------------------------------
    // Flags
    //----------------------------------------------------------

    assign op1_sgn     = op1_i[ialu_pkg::XLEN-1];
    assign op2_eff_sgn = op2_i[ialu_pkg::XLEN-1] ^ is_sub;  // Negated op2 for SUB
    assign res_sgn     = sum_full[ialu_pkg::XLEN-1];

    always_comb begin
        flags_o.c = sum_full[ialu_pkg::XLEN];           // Borrow when op1 < op2 unsigned
        flags_o.z = ~|sum_full[ialu_pkg::XLEN-1:0];
        flags_o.s = res_sgn;
        // Same-sign operands giving an opposite-sign result
        flags_o.o = (op1_sgn == op2_eff_sgn) & (res_sgn != op1_sgn);
    end

endmodule : ialu_main_adder

// File: src/ialu_shift_logic.sv
//----------------------------------------------------------
// IALU shifter and bitwise logic
// SLL, SRL, SRA by op2[4:0], plus AND, OR and XOR
//----------------------------------------------------------

`timescale 1ns/1ns

module ialu_shift_logic (
    input  ialu_pkg::ialu_cmd_e          cmd_i,     // IALU command
    input  logic [ialu_pkg::XLEN-1:0]    op1_i,     // Value to shift, 1st logic operand
    input  logic [ialu_pkg::XLEN-1:0]    op2_i,     // Shift amount, 2nd logic operand
    output logic [ialu_pkg::XLEN-1:0]    shl_res_o  // Shift or logic result
);

    logic [1:0]                         shft_kind;  // 00 left, 10 right, 11 arith right
    logic signed [ialu_pkg::XLEN-1:0]   shft_op1;   // Signed so >>> fills with sign
    logic [ialu_pkg::SHAMT_W-1:0]       shft_amt;
    logic [ialu_pkg::XLEN-1:0]          shft_res;

    //----------------------------------------------------------
    // Shifter
    //----------------------------------------------------------

    assign shft_kind = {(cmd_i != ialu_pkg::SLL), (cmd_i == ialu_pkg::SRA)};
    assign shft_op1  = op1_i;
    assign shft_amt  = op2_i[ialu_pkg::SHAMT_W-1:0];

    always_comb begin
        case (shft_kind)
            2'b10   : shft_res = shft_op1 >> shft_amt;
            2'b11   : shft_res = shft_op1 >>> shft_amt;
            default : shft_res = shft_op1 << shft_amt;
        endcase
    end

    // Zero for commands owned by other units
    always_comb begin
        case (cmd_i)
            ialu_pkg::SLL, ialu_pkg::SRL, ialu_pkg::SRA : shl_res_o = shft_res;
            ialu_pkg::AND : shl_res_o = op1_i & op2_i;
            ialu_pkg::OR  : shl_res_o = op1_i | op2_i;
            ialu_pkg::XOR : shl_res_o = op1_i ^ op2_i;
            default       : shl_res_o = '0;
        endcase
    end

endmodule : ialu_shift_logic

// File: src/ialu_mul_seq.sv
//----------------------------------------------------------
// IALU radix-2 sequential multiplier
// MUL, MULH, MULHSU, MULHU, one multiplier bit per cycle,
// a single 33-bit adder and shared high/low result registers
//----------------------------------------------------------

`timescale 1ns/1ns

module ialu_mul_seq (
    input  logic                        clk,
    input  logic                        rst_n,
    input  ialu_pkg::ialu_cmd_e         cmd_i,          // IALU command
    input  logic [ialu_pkg::XLEN-1:0]   op1_i,          // Multiplicand
    input  logic [ialu_pkg::XLEN-1:0]   op2_i,          // Multiplier
    input  logic                        mdu_cmd_vd_i,   // Command valid, held until ready
    output logic [ialu_pkg::XLEN-1:0]   mul_res_o,      // Selected product word
    output logic                        mul_rdy_o       // Result valid this cycle
);

    // Command decode
    logic                               is_mul;
    logic                               is_hi;          // Upper word requested
    logic                               op1_is_sgn;
    logic                               op2_is_sgn;
    logic                               ops_non_zero;

    // FSM and counter
    ialu_pkg::mdu_state_e               state_ff;
    ialu_pkg::mdu_state_e               state_next;
    logic                               state_idle;
    logic                               iter_req;       // Start of an iterative multiply
    logic                               res_upd;        // Advance registers this cycle
    logic [ialu_pkg::XLEN-1:0]          cnt_ff;         // One-hot, bit 0 marks last step
    logic [ialu_pkg::XLEN-1:0]          cnt_next;

    // Datapath
    logic signed [ialu_pkg::XLEN:0]     mul_op1;        // Sign- or zero-extended op1
    logic [ialu_pkg::XLEN-1:0]          lo_src;         // op2 on first step, then lo_ff
    logic                               mul_bit;        // Current multiplier bit
    logic                               mul_neg;        // Signed weight on the last step
    logic signed [ialu_pkg::XLEN:0]     part_prod;
    logic signed [ialu_pkg::XLEN:0]     sum_op1;        // Extended high register
    logic signed [ialu_pkg::XLEN:0]     sum_res;        // MDU adder output
    logic [ialu_pkg::XLEN-1:0]          mul_res_hi;
    logic [ialu_pkg::XLEN-1:0]          mul_res_lo;
    logic [ialu_pkg::XLEN-1:0]          hi_ff;
    logic [ialu_pkg::XLEN-1:0]          lo_ff;

    //----------------------------------------------------------
    // Command decode
    //----------------------------------------------------------

    assign is_mul = (cmd_i == ialu_pkg::MUL)    | (cmd_i == ialu_pkg::MULH)
                  | (cmd_i == ialu_pkg::MULHSU) | (cmd_i == ialu_pkg::MULHU);
    assign is_hi      = is_mul & (cmd_i != ialu_pkg::MUL);
    assign op1_is_sgn = (cmd_i != ialu_pkg::MULHU);
    assign op2_is_sgn = (cmd_i == ialu_pkg::MUL) | (cmd_i == ialu_pkg::MULH);
    assign ops_non_zero = (|op1_i) & (|op2_i);      // Zero operand is answered in IDLE

    //----------------------------------------------------------
    // FSM
    //----------------------------------------------------------

    assign state_idle = (state_ff == ialu_pkg::IDLE);
    assign iter_req   = is_mul & ops_non_zero & state_idle;
    assign mul_rdy_o  = state_idle ? ~iter_req : cnt_ff[0];
    assign res_upd    = mdu_cmd_vd_i & is_mul & ~mul_rdy_o;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state_ff <= ialu_pkg::IDLE;
        end else begin
            state_ff <= state_next;
        end
    end

    always_comb begin
        state_next = ialu_pkg::IDLE;                // Dropped valid returns to IDLE
        if (mdu_cmd_vd_i) begin
            case (state_ff)
                ialu_pkg::IDLE : state_next = iter_req ? ialu_pkg::ITER : ialu_pkg::IDLE;
                ialu_pkg::ITER : state_next = cnt_ff[0] ? ialu_pkg::IDLE : ialu_pkg::ITER;
                default        : state_next = ialu_pkg::IDLE;
            endcase
        end
    end

    // Iteration counter
    assign cnt_next = state_idle ? ialu_pkg::MUL_CNT_INIT : (cnt_ff >> 1);

    always_ff @(posedge clk) begin
        if (res_upd) begin
            cnt_ff <= cnt_next;
        end
    end

    //----------------------------------------------------------
    // Partial product and MDU adder
    //----------------------------------------------------------

    assign mul_op1   = $signed({op1_is_sgn & op1_i[ialu_pkg::XLEN-1], op1_i});
    assign lo_src    = state_idle ? op2_i : lo_ff;
    assign mul_bit   = lo_src[0];
    assign mul_neg   = ~state_idle & cnt_ff[0] & op2_is_sgn;    // Bit 31 weighs -2^31
    assign part_prod = ~mul_bit ? '0 : (mul_neg ? -mul_op1 : mul_op1);

    assign sum_op1 = state_idle ? '0
                   : $signed({op1_is_sgn & hi_ff[ialu_pkg::XLEN-1], hi_ff});
    assign sum_res = sum_op1 + part_prod;

    // Whole 64-bit accumulator shifts right by one per step
    assign {mul_res_hi, mul_res_lo} = {sum_res, lo_src[ialu_pkg::XLEN-1:1]};

    always_ff @(posedge clk) begin
        if (res_upd) begin
            hi_ff <= mul_res_hi;
            lo_ff <= mul_res_lo;
        end
    end

    // Zero in IDLE covers the zero-operand case
    assign mul_res_o = state_idle ? '0 : (is_hi ? mul_res_hi : mul_res_lo);

endmodule : ialu_mul_seq

// File: src/ialu_result_mux.sv
//----------------------------------------------------------
// IALU result multiplexer
// Picks the unit result, forms compare bits from the flags
//----------------------------------------------------------

`timescale 1ns/1ns

module ialu_result_mux (
    input  ialu_pkg::ialu_cmd_e         cmd_i,          // IALU command
    input  logic [ialu_pkg::XLEN-1:0]   sum_i,          // Main adder result
    input  ialu_pkg::ialu_flags_s       flags_i,        // Main adder flags
    input  logic [ialu_pkg::XLEN-1:0]   shl_res_i,      // Shift / logic result
    input  logic [ialu_pkg::XLEN-1:0]   mul_res_i,      // Multiplier result
    input  logic                        mul_rdy_i,      // Multiplier ready
    output logic [ialu_pkg::XLEN-1:0]   res_o,          // IALU result
    output logic                        cmp_res_o,      // Branch condition
    output logic                        mdu_res_rdy_o   // Result ready for MUL commands
);

    logic cond_lt;                                      // Signed op1 < op2
    logic cond_ltu;                                     // Unsigned op1 < op2
    logic cond_eq;

    assign cond_lt  = flags_i.s ^ flags_i.o;
    assign cond_ltu = flags_i.c;
    assign cond_eq  = flags_i.z;

    //----------------------------------------------------------
    // Comparison bit
    //----------------------------------------------------------

    always_comb begin
        case (cmd_i)
            ialu_pkg::SUB_LT  : cmp_res_o = cond_lt;
            ialu_pkg::SUB_LTU : cmp_res_o = cond_ltu;
            ialu_pkg::SUB_EQ  : cmp_res_o = cond_eq;
            ialu_pkg::SUB_NE  : cmp_res_o = ~cond_eq;
            ialu_pkg::SUB_GE  : cmp_res_o = ~cond_lt;
            ialu_pkg::SUB_GEU : cmp_res_o = ~cond_ltu;
            default           : cmp_res_o = 1'b0;
        endcase
    end

    //----------------------------------------------------------
    // Result and ready
    //----------------------------------------------------------

    always_comb begin
        res_o         = '0;
        mdu_res_rdy_o = 1'b1;                           // Single-cycle unless multiplying
        case (cmd_i)
            ialu_pkg::ADD, ialu_pkg::SUB : res_o = sum_i;
            ialu_pkg::SUB_LT, ialu_pkg::SUB_LTU, ialu_pkg::SUB_EQ,
            ialu_pkg::SUB_NE, ialu_pkg::SUB_GE, ialu_pkg::SUB_GEU : begin
                res_o = {{(ialu_pkg::XLEN-1){1'b0}}, cmp_res_o};   // Set result
            end
            ialu_pkg::AND, ialu_pkg::OR, ialu_pkg::XOR,
            ialu_pkg::SLL, ialu_pkg::SRL, ialu_pkg::SRA : res_o = shl_res_i;
            ialu_pkg::MUL, ialu_pkg::MULH, ialu_pkg::MULHSU, ialu_pkg::MULHU : begin
                res_o         = mul_res_i;
                mdu_res_rdy_o = mul_rdy_i;
            end
            default : res_o = '0;
        endcase
    end

endmodule : ialu_result_mux

// File: src/ialu_top.sv
//----------------------------------------------------------
// IALU top level
// Adder, shift/logic, sequential multiplier and result mux
//----------------------------------------------------------

`timescale 1ns/1ns

module ialu_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  ialu_pkg::ialu_cmd_e         cmd_i,          // IALU command from execute stage
    input  logic [ialu_pkg::XLEN-1:0]   op1_i,
    input  logic [ialu_pkg::XLEN-1:0]   op2_i,
    input  logic                        mdu_cmd_vd_i,   // Multiply command valid
    output logic [ialu_pkg::XLEN-1:0]   res_o,
    output logic                        cmp_res_o,
    output logic                        mdu_res_rdy_o
);

    logic [ialu_pkg::XLEN-1:0]  sum;
    ialu_pkg::ialu_flags_s      flags;
    logic [ialu_pkg::XLEN-1:0]  shl_res;
    logic [ialu_pkg::XLEN-1:0]  mul_res;
    logic                       mul_rdy;

    ialu_main_adder u_adder (
        .cmd_i      (cmd_i),
        .op1_i      (op1_i),
        .op2_i      (op2_i),
        .sum_o      (sum),
        .flags_o    (flags)
    );

    ialu_shift_logic u_shift_logic (
        .cmd_i      (cmd_i),
        .op1_i      (op1_i),
        .op2_i      (op2_i),
        .shl_res_o  (shl_res)
    );

    ialu_mul_seq u_mul (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmd_i          (cmd_i),
        .op1_i          (op1_i),
        .op2_i          (op2_i),
        .mdu_cmd_vd_i   (mdu_cmd_vd_i),
        .mul_res_o      (mul_res),
        .mul_rdy_o      (mul_rdy)
    );

    ialu_result_mux u_res_mux (
        .cmd_i          (cmd_i),
        .sum_i          (sum),
        .flags_i        (flags),
        .shl_res_i      (shl_res),
        .mul_res_i      (mul_res),
        .mul_rdy_i      (mul_rdy),
        .res_o          (res_o),
        .cmp_res_o      (cmp_res_o),
        .mdu_res_rdy_o  (mdu_res_rdy_o)
    );

endmodule : ialu_top

// File: bench/ialu_ref_model.svh
//----------------------------------------------------------
// IALU reference model
// Expected results for the IALU testbench
//----------------------------------------------------------

`ifndef IALU_REF_MODEL_SVH
`define IALU_REF_MODEL_SVH

// ADD wraps mod 2^32, everything else subtracts
function automatic logic [31:0] ref_addsub(input ialu_pkg::ialu_cmd_e c,
                                           input logic [31:0] a, input logic [31:0] b);
    return (c == ialu_pkg::ADD) ? a + b : a - b;
endfunction

function automatic logic [31:0] ref_logic(input ialu_pkg::ialu_cmd_e c,
                                          input logic [31:0] a, input logic [31:0] b);
    case (c)
        ialu_pkg::AND : return a & b;
        ialu_pkg::OR  : return a | b;
        default       : return a ^ b;
    endcase
endfunction

// Branch condition, signed or unsigned
function automatic logic ref_cmp(input ialu_pkg::ialu_cmd_e c,
                                 input logic [31:0] a, input logic [31:0] b);
    logic lt_s;
    logic lt_u;
    lt_s = $signed(a) < $signed(b);
    lt_u = a < b;
    case (c)
        ialu_pkg::SUB_LT  : return lt_s;
        ialu_pkg::SUB_LTU : return lt_u;
        ialu_pkg::SUB_EQ  : return a == b;
        ialu_pkg::SUB_NE  : return a != b;
        ialu_pkg::SUB_GE  : return ~lt_s;
        ialu_pkg::SUB_GEU : return ~lt_u;
        default           : return 1'b0;
    endcase
endfunction

// Shift by b[4:0], SRA fills the vacated bits with a[31]
function automatic logic [31:0] ref_shift(input ialu_pkg::ialu_cmd_e c,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [4:0] amt;
    amt = b[4:0];
    case (c)
        ialu_pkg::SLL : return a << amt;
        ialu_pkg::SRL : return a >> amt;
        default       : return (a >> amt) | (a[31] ? ~(32'hFFFF_FFFF >> amt) : 32'h0);
    endcase
endfunction

// 64-bit product of the extended operands, word picked by command
function automatic logic [31:0] ref_mul(input ialu_pkg::ialu_cmd_e c,
                                        input logic [31:0] a, input logic [31:0] b);
    logic [63:0] a_ext;
    logic [63:0] b_ext;
    logic [63:0] prod;
    a_ext = (c != ialu_pkg::MULHU) ? {{32{a[31]}}, a} : {32'h0, a};
    b_ext = (c == ialu_pkg::MUL || c == ialu_pkg::MULH) ? {{32{b[31]}}, b} : {32'h0, b};
    prod  = a_ext * b_ext;                      // Low 64 bits are exact
    return (c == ialu_pkg::MUL) ? prod[31:0] : prod[63:32];
endfunction

`endif

// File: bench/ialu_tb.sv
//----------------------------------------------------------
// IALU testbench
// Random and corner vectors for every command group
//----------------------------------------------------------

`timescale 1ns/1ns

module ialu_tb;

    localparam int     CLK_PERIOD  = 20;
    localparam int     RST_CYCLES  = 10;
    localparam int     DRIVE_DLY   = 2;         // Inputs change after the edge
    localparam int     NUM_TESTS   = 6;
    localparam int     NUM_VECS    = 200;
    localparam int     MUL_VECS    = 40;        // Per multiply command
    localparam int     RDY_LIMIT   = 40;        // Cycles to wait for ready
    localparam int     WATCHDOG_NS = (NUM_TESTS * NUM_VECS * 40 + RST_CYCLES) * CLK_PERIOD;

    logic                clk;
    logic                rst_n;
    ialu_pkg::ialu_cmd_e cmd;
    logic [31:0]         op1;
    logic [31:0]         op2;
    logic                mdu_cmd_vd;
    logic [31:0]         res;
    logic                cmp_res;
    logic                mdu_res_rdy;
    logic                is_mul_cmd;

    integer seed;
    int     err_cnt;
    int     chk_cnt;
    int     test_cnt;
    int     err_at_start;
    int     chk_at_start;

    `include "ialu_ref_model.svh"

    ialu_top u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmd_i          (cmd),
        .op1_i          (op1),
        .op2_i          (op2),
        .mdu_cmd_vd_i   (mdu_cmd_vd),
        .res_o          (res),
        .cmp_res_o      (cmp_res),
        .mdu_res_rdy_o  (mdu_res_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Ends a hung run
    initial begin
        #WATCHDOG_NS;
        $display("Run timed out after %0d ns", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $finish;
    end

    //----------------------------------------------------------
    // Handshake assertion
    //----------------------------------------------------------

    assign is_mul_cmd = cmd inside {ialu_pkg::MUL, ialu_pkg::MULH,
                                    ialu_pkg::MULHSU, ialu_pkg::MULHU};

    // Single-cycle commands always report ready
    rdy_single_cycle : assert property (@(posedge clk) disable iff (!rst_n)
                                        is_mul_cmd || mdu_res_rdy)
        else begin
            $display("%0t: result-ready was low for a single-cycle command", $time);
            err_cnt++;
        end

    //----------------------------------------------------------
    // Helper tasks
    //----------------------------------------------------------

    task automatic drive(input ialu_pkg::ialu_cmd_e c, input logic [31:0] a,
                         input logic [31:0] b, input logic vd);
        @(posedge clk);
        #DRIVE_DLY;
        cmd        = c;
        op1        = a;
        op2        = b;
        mdu_cmd_vd = vd;
    endtask

    task automatic apply_comb(input ialu_pkg::ialu_cmd_e c, input logic [31:0] a,
                              input logic [31:0] b);
        drive(c, a, b, 1'b0);
        @(negedge clk);                         // Sample once outputs settle
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        chk_cnt++;
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic start_test();
        err_at_start = err_cnt;
        chk_at_start = chk_cnt;
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        $display("Test %-12s done: %0d checks, %0d errors", name,
                 chk_cnt - chk_at_start, err_cnt - err_at_start);
    endtask

    // Holds valid until ready, then drops it for one cycle
    task automatic run_mul(input ialu_pkg::ialu_cmd_e c, input logic [31:0] a,
                           input logic [31:0] b, input int exp_cycle);
        int          cyc;
        logic [31:0] exp;
        exp = ref_mul(c, a, b);
        drive(c, a, b, 1'b1);
        cyc = 1;                                // Cycle 1 is the IDLE step
        @(negedge clk);
        while (!mdu_res_rdy && cyc < RDY_LIMIT) begin
            @(negedge clk);
            cyc++;
        end
        chk_cnt++;
        assert (mdu_res_rdy) else begin
            $display("%0t: multiply result-ready never rose for %s", $time, c.name());
            err_cnt++;
        end
        if (mdu_res_rdy) begin
            chk_cnt++;
            assert (cyc == exp_cycle) else begin
                $display("%0t: %s result-ready rose in cycle %0d instead of cycle %0d",
                         $time, c.name(), cyc, exp_cycle);
                err_cnt++;
            end
            check_value({c.name(), " result"}, res, exp);
        end
        drive(ialu_pkg::NONE, 32'h0, 32'h0, 1'b0);     // One idle cycle
    endtask

    //----------------------------------------------------------
    // Tests
    //----------------------------------------------------------

    task automatic test_add_sub();
        logic [31:0] a;
        logic [31:0] b;
        start_test();
        repeat (NUM_VECS) begin
            a = $random(seed);
            b = $random(seed);
            apply_comb(ialu_pkg::ADD, a, b);
            check_value("ADD", res, ref_addsub(ialu_pkg::ADD, a, b));
            check_value("ADD ready", 32'(mdu_res_rdy), 32'h1);
            apply_comb(ialu_pkg::SUB, a, b);
            check_value("SUB", res, ref_addsub(ialu_pkg::SUB, a, b));
            check_value("SUB ready", 32'(mdu_res_rdy), 32'h1);
        end
        finish_test("add_sub");
    endtask

    task automatic test_logic();
        logic [31:0]         a;
        logic [31:0]         b;
        ialu_pkg::ialu_cmd_e c;
        start_test();
        repeat (NUM_VECS) begin
            a = $random(seed);
            b = $random(seed);
            for (int k = 0; k < 3; k++) begin
                c = ialu_pkg::ialu_cmd_e'(ialu_pkg::AND + k);   // AND, OR, XOR
                apply_comb(c, a, b);
                check_value(c.name(), res, ref_logic(c, a, b));
            end
        end
        finish_test("logic");
    endtask

    task automatic test_compare();
        logic [31:0]         a;
        logic [31:0]         b;
        logic                exp;
        ialu_pkg::ialu_cmd_e c;
        start_test();
        for (int i = 0; i < NUM_VECS; i++) begin
            a = $random(seed);
            b = $random(seed);
            case (i)                            // Corner pairs first
                0 : b = a;
                1 : begin
                    a = 32'h8000_0000;
                    b = 32'h7FFF_FFFF;
                end
                2 : begin
                    a = 32'h7FFF_FFFF;
                    b = 32'h8000_0000;
                end
                3 : begin
                    a = 32'h0;
                    b = 32'hFFFF_FFFF;
                end
                4 : begin
                    a = 32'hFFFF_FFFF;
                    b = 32'h0;
                end
                default : ;
            endcase
            for (int k = 0; k < 6; k++) begin
                c   = ialu_pkg::ialu_cmd_e'(ialu_pkg::SUB_LT + k);
                exp = ref_cmp(c, a, b);
                apply_comb(c, a, b);
                check_value({c.name(), " branch"}, 32'(cmp_res), 32'(exp));
                check_value({c.name(), " set"}, res, {31'h0, exp});
            end
        end
        finish_test("compare");
    endtask

    task automatic test_shift();
        logic [31:0]         a;
        logic [31:0]         b;
        logic [4:0]          amt;
        ialu_pkg::ialu_cmd_e c;
        start_test();
        for (int i = 0; i < NUM_VECS; i++) begin
            a   = $random(seed);
            b   = $random(seed);
            amt = (i == 0) ? 5'd0 : (i == 1) ? 5'd31 : b[4:0];
            b   = {b[31:5], amt};
            if (i < 4) a[31] = 1'b1;            // Negative values for SRA fill
            for (int k = 0; k < 3; k++) begin
                c = ialu_pkg::ialu_cmd_e'(ialu_pkg::SLL + k);
                apply_comb(c, a, b);
                check_value(c.name(), res, ref_shift(c, a, b));
            end
        end
        finish_test("shift");
    endtask

    task automatic test_mul_nonzero();
        logic [31:0]         a;
        logic [31:0]         b;
        ialu_pkg::ialu_cmd_e c;
        start_test();
        for (int k = 0; k < 4; k++) begin
            c = ialu_pkg::ialu_cmd_e'(ialu_pkg::MUL + k);
            for (int v = 0; v < MUL_VECS; v++) begin
                a = $random(seed);
                b = $random(seed);
                case (v)
                    0 : a = 32'hFFFF_FFFF;      // -1
                    1 : b = 32'h8000_0000;
                    2 : begin
                        a = 32'h8000_0000;
                        b = 32'hFFFF_FFFF;
                    end
                    3 : begin
                        a = 32'h8000_0000;
                        b = 32'h8000_0000;
                    end
                    default : ;
                endcase
                if (a == 32'h0) a = 32'h1;      // Keep the iterative path
                if (b == 32'h0) b = 32'h1;
                run_mul(c, a, b, 32);
            end
        end
        finish_test("mul");
    endtask

    task automatic test_mul_zero();
        logic [31:0]         x;
        ialu_pkg::ialu_cmd_e c;
        start_test();
        for (int k = 0; k < 4; k++) begin
            c = ialu_pkg::ialu_cmd_e'(ialu_pkg::MUL + k);
            for (int v = 0; v < 8; v++) begin
                x = $random(seed);
                run_mul(c, 32'h0, x, 1);
                run_mul(c, x, 32'h0, 1);
            end
            run_mul(c, 32'h0, 32'h0, 1);
        end
        finish_test("mul_zero");
    endtask

    //----------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------

    initial begin
        seed       = 45983;
        err_cnt    = 0;
        chk_cnt    = 0;
        test_cnt   = 0;
        rst_n      = 1'b0;
        cmd        = ialu_pkg::NONE;
        op1        = 32'h0;
        op2        = 32'h0;
        mdu_cmd_vd = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        test_add_sub();
        test_logic();
        test_compare();
        test_shift();
        test_mul_nonzero();
        test_mul_zero();

        $display("Tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : ialu_tb

// File: flist.f
+incdir+bench
src/ialu_pkg.sv
src/ialu_main_adder.sv
src/ialu_shift_logic.sv
src/ialu_mul_seq.sv
src/ialu_result_mux.sv
src/ialu_top.sv
bench/ialu_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the IALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module ialu_tb -o ialu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/ialu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
    exit 0
fi
echo "Simulation reported failures, see $LOG"
exit 1
